//--- verilog/display_consts.svh
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

//////////////////////////////////////////////////
// raster timing, short frame for simulation
//////////////////////////////////////////////////

`define H_ACTIVE      64
`define H_FRONT       4
`define H_SYNC        8
`define H_BACK        4
`define H_TOTAL       (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)  // 80 clocks per line
`define H_SYNC_START  (`H_ACTIVE + `H_FRONT)
`define H_SYNC_END    (`H_ACTIVE + `H_FRONT + `H_SYNC)            // first pixel after hsync

`define V_ACTIVE      48
`define V_FRONT       2
`define V_SYNC        2
`define V_BACK        2
`define V_TOTAL       (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)  // 54 lines per frame
`define V_SYNC_START  (`V_ACTIVE + `V_FRONT)
`define V_SYNC_END    (`V_ACTIVE + `V_FRONT + `V_SYNC)

//////////////////////////////////////////////////
// sprite
//////////////////////////////////////////////////

`define SPRITE_SIZE      24          // side of the square, even
`define BODY_COLOR       24'hff_ff_ff
`define BLANK_COLOR      24'h00_00_00
`define INDICATOR_COLOR  24'h00_ff_00

// tangents as fractions of 64
`define TAN_SHIFT    6
`define TAN15_NUM    17
`define TAN30_NUM    37
`define TAN60_NUM    111
`define TAN75_NUM    240
`define TAN75_SLACK  2               // steep line needs extra width to stay connected

`endif

//--- verilog/display_pkg.sv
package display_pkg;

    //////////////////////////////////////////////////
    // screen geometry
    //////////////////////////////////////////////////

    // signed so sprite centres can sit off the left or top edge
    typedef logic signed [11:0] coord_t;

    //////////////////////////////////////////////////
    // pixel data
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [7:0] red;   // msb byte, matches 24'hRR_GG_BB constants
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // heading in 15 degree steps, 0 is east, 6 is north
    typedef logic [4:0] heading_t;

    //////////////////////////////////////////////////
    // raster control levels
    //////////////////////////////////////////////////

    typedef struct packed {
        logic hsync; // active high
        logic vsync; // active high
        logic blank; // high outside the visible area
    } sync_t;

endpackage

//--- verilog/delay_line.sv
module delay_line #(
    parameter type      payload_t   = logic,
    parameter int       DEPTH       = 1,     // number of register stages
    parameter payload_t RESET_VALUE = '0
) (
    input  logic     vclock,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];                 // stage 0 takes din

    if (DEPTH < 1) begin : g_depth_check
        $error("delay_line DEPTH must be at least 1");
    end

    always_ff @(posedge vclock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= RESET_VALUE;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];      // shift toward dout
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

//--- verilog/raster_timing.sv
`include "display_consts.svh"

module raster_timing (
    input  logic                vclock,
    input  logic                rst,
    output display_pkg::coord_t hcount,
    output display_pkg::coord_t vcount,
    output display_pkg::sync_t  sync,
    output logic                frame_end
);
    import display_pkg::*;

    coord_t h_next;   // counts loaded at the coming edge
    coord_t v_next;
    logic   h_wrap;   // hcount on the last pixel of a line
    logic   v_wrap;   // vcount on the last line of a frame

    // sync and blank levels for one raster position
    function automatic sync_t decode_sync(coord_t h, coord_t v);
        sync_t s;
        s.hsync = (h >= `H_SYNC_START) && (h < `H_SYNC_END);
        s.vsync = (v >= `V_SYNC_START) && (v < `V_SYNC_END);
        s.blank = (h >= `H_ACTIVE) || (v >= `V_ACTIVE);
        return s;
    endfunction

    //////////////////////////////////////////////////
    // next count
    //////////////////////////////////////////////////

    assign h_wrap = (hcount == `H_TOTAL - 1);
    assign v_wrap = (vcount == `V_TOTAL - 1);

    assign h_next = h_wrap ? coord_t'(0) : hcount + coord_t'(1);

    always_comb begin
        v_next = vcount;                 // hold within a line
        if (h_wrap) begin
            v_next = v_wrap ? coord_t'(0) : vcount + coord_t'(1);
        end
    end

    //////////////////////////////////////////////////
    // counters and registered decode
    //////////////////////////////////////////////////

    // decoding from the next counts keeps every output a flop
    // and still lined up with hcount / vcount
    always_ff @(posedge vclock) begin
        if (rst) begin
            hcount    <= '0;
            vcount    <= '0;
            sync      <= decode_sync(coord_t'(0), coord_t'(0)); // levels of pixel 0,0
            frame_end <= 1'b0;
        end else begin
            hcount    <= h_next;
            vcount    <= v_next;
            sync      <= decode_sync(h_next, v_next);
            // high only while the counters sit on the very last position
            frame_end <= (h_next == `H_TOTAL - 1) && (v_next == `V_TOTAL - 1);
        end
    end

endmodule

//--- verilog/position_register.sv
module position_register (
    input  logic                  vclock,
    input  logic                  rst,
    input  logic                  load,
    input  display_pkg::coord_t   new_x,
    input  display_pkg::coord_t   new_y,
    input  display_pkg::heading_t new_heading,
    input  logic                  frame_end,
    output display_pkg::coord_t   center_x,
    output display_pkg::coord_t   center_y,
    output display_pkg::heading_t heading
);
    import display_pkg::*;

    coord_t   pend_x;        // last loaded, waiting for frame end
    coord_t   pend_y;
    heading_t pend_heading;

    //////////////////////////////////////////////////
    // double buffer
    //////////////////////////////////////////////////

    always_ff @(posedge vclock) begin
        if (rst) begin
            pend_x       <= '0;
            pend_y       <= '0;
            pend_heading <= '0;
            center_x     <= '0;
            center_y     <= '0;
            heading      <= '0;
        end else begin
            if (load) begin              // later loads simply overwrite
                pend_x       <= new_x;
                pend_y       <= new_y;
                pend_heading <= new_heading;
            end
            // swap reads the old pending values, so a load on the
            // frame_end cycle waits one more frame
            if (frame_end) begin
                center_x <= pend_x;
                center_y <= pend_y;
                heading  <= pend_heading;
            end
        end
    end

endmodule

//--- verilog/heading_sprite.sv
`include "display_consts.svh"

module heading_sprite (
    input  logic                  vclock,
    input  logic                  rst,
    input  display_pkg::coord_t   hcount,
    input  display_pkg::coord_t   vcount,
    input  display_pkg::coord_t   center_x,
    input  display_pkg::coord_t   center_y,
    input  display_pkg::heading_t heading,
    output display_pkg::rgb_t     pixel
);
    import display_pkg::*;

    localparam int HALF = `SPRITE_SIZE / 2;

    logic signed [12:0] dx;   // one bit wider than a coordinate so the difference never wraps
    logic signed [12:0] dy;
    logic [12:0] ax;          // magnitudes
    logic [12:0] ay;
    logic        in_box;
    logic        on_00, on_15, on_30, on_45, on_60, on_75, on_90;
    logic        on_ray;
    logic [1:0]  quad;
    logic        in_quad;
    logic [20:0] q75;

    // floor(a * num / 64) on a magnitude
    function automatic logic [20:0] tan_floor(logic [12:0] a, int num);
        logic [20:0] prod;
        prod = 21'(a) * 21'(num);
        return prod >> `TAN_SHIFT;
    endfunction

    //////////////////////////////////////////////////
    // offsets and box
    //////////////////////////////////////////////////

    assign dx = hcount - center_x;
    assign dy = vcount - center_y;
    assign ax = (dx < 0) ? 13'(-dx) : 13'(dx);
    assign ay = (dy < 0) ? 13'(-dy) : 13'(dy);

    assign in_box = (dx >= -HALF) && (dx < HALF)
                 && (dy >= -HALF) && (dy < HALF);     // half-open 24 x 24 square

    //////////////////////////////////////////////////
    // ray lines folded into the first quadrant
    //////////////////////////////////////////////////

    assign on_00 = (ay == '0) && (ax != '0);
    assign on_90 = (ax == '0) && (ay != '0);
    assign on_45 = (ax == ay);                        // includes the centre pixel
    assign on_15 = (tan_floor(ax, `TAN15_NUM) == 21'(ay));
    assign on_30 = (tan_floor(ax, `TAN30_NUM) == 21'(ay));
    assign on_60 = (tan_floor(ax, `TAN60_NUM) == 21'(ay));
    assign q75   = tan_floor(ax, `TAN75_NUM);
    // t = q75 - ay in [-slack, 0]
    assign on_75 = (q75 <= 21'(ay)) && (q75 + 21'(`TAN75_SLACK) >= 21'(ay));

    assign on_ray = on_00 | on_15 | on_30 | on_45 | on_60 | on_75 | on_90;

    // heading / 6 where codes above 23 stay in quadrant 3
    assign quad = (heading < 5'd6)  ? 2'd0 :
                  (heading < 5'd12) ? 2'd1 :
                  (heading < 5'd18) ? 2'd2 : 2'd3;

    always_comb begin
        case (quad)                                   // screen y grows downward
            2'd0:    in_quad = (dx >= 0) && (dy <= 0);
            2'd1:    in_quad = (dx <= 0) && (dy <= 0);
            2'd2:    in_quad = (dx <= 0) && (dy >= 0);
            default: in_quad = (dx >= 0) && (dy >= 0);
        endcase
    end

    //////////////////////////////////////////////////
    // pixel register
    //////////////////////////////////////////////////

    always_ff @(posedge vclock) begin
        if (rst) begin
            pixel <= rgb_t'(`BLANK_COLOR);
        end else if (in_box && on_ray && in_quad) begin
            pixel <= rgb_t'(`INDICATOR_COLOR);
        end else if (in_box) begin
            pixel <= rgb_t'(`BODY_COLOR);
        end else begin
            pixel <= rgb_t'(`BLANK_COLOR);
        end
    end

endmodule

//--- verilog/video_out.sv
`include "display_consts.svh"

module video_out (
    input  logic               vclock,
    input  logic               rst,
    input  display_pkg::sync_t sync_in,
    input  display_pkg::rgb_t  pixel,
    output display_pkg::rgb_t  rgb,
    output logic               hsync,
    output logic               vsync,
    output logic               blank
);
    import display_pkg::*;

    // syncs idle, picture blanked while the pipe fills
    localparam sync_t SYNC_IDLE = '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1};

    logic  blank_d1;   // blank lined up with the sprite pixel
    rgb_t  rgb_next;
    sync_t sync_d2;    // sync lined up with rgb

    always_ff @(posedge vclock) begin
        if (rst) begin
            blank_d1 <= 1'b1;
        end else begin
            blank_d1 <= sync_in.blank;
        end
    end

    assign rgb_next = blank_d1 ? rgb_t'(`BLANK_COLOR) : pixel;   // only blank gate

    //////////////////////////////////////////////////
    // output alignment
    //////////////////////////////////////////////////

    delay_line #(.payload_t(sync_t), .DEPTH(2), .RESET_VALUE(SYNC_IDLE)) sync_delay_i (
        .vclock (vclock),
        .rst    (rst),
        .din    (sync_in),
        .dout   (sync_d2)
    );

    delay_line #(
        .payload_t   (rgb_t),
        .DEPTH       (1),
        .RESET_VALUE (rgb_t'(`BLANK_COLOR))
    ) rgb_delay_i (
        .vclock (vclock),
        .rst    (rst),
        .din    (rgb_next),
        .dout   (rgb)
    );

    assign hsync = sync_d2.hsync;
    assign vsync = sync_d2.vsync;
    assign blank = sync_d2.blank;

endmodule

//--- verilog/phone_display.sv
module phone_display (
    input  logic                  vclock,
    input  logic                  rst,
    input  logic                  load,
    input  display_pkg::coord_t   new_x,
    input  display_pkg::coord_t   new_y,
    input  display_pkg::heading_t new_heading,
    output display_pkg::rgb_t     rgb,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  blank
);
    import display_pkg::*;

    coord_t   hcount;      // raster position, cycle 0 of the pipe
    coord_t   vcount;
    sync_t    sync;
    logic     frame_end;
    coord_t   center_x;    // active position, steady for a whole frame
    coord_t   center_y;
    heading_t heading;
    rgb_t     pixel;       // sprite colour, one cycle behind the counters

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    raster_timing raster_timing_i (
        .vclock    (vclock),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .sync      (sync),
        .frame_end (frame_end)
    );

    position_register position_register_i (
        .vclock      (vclock),
        .rst         (rst),
        .load        (load),
        .new_x       (new_x),
        .new_y       (new_y),
        .new_heading (new_heading),
        .frame_end   (frame_end),
        .center_x    (center_x),
        .center_y    (center_y),
        .heading     (heading)
    );

    //////////////////////////////////////////////////
    // sprite and output side
    //////////////////////////////////////////////////

    heading_sprite heading_sprite_i (
        .vclock   (vclock),
        .rst      (rst),
        .hcount   (hcount),
        .vcount   (vcount),
        .center_x (center_x),
        .center_y (center_y),
        .heading  (heading),
        .pixel    (pixel)
    );

    video_out video_out_i (
        .vclock  (vclock),
        .rst     (rst),
        .sync_in (sync),
        .pixel   (pixel),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync),
        .blank   (blank)
    );

endmodule

//--- bench/display_assertions.sv
`include "display_consts.svh"

module display_assertions (
    input logic              vclock,
    input logic              rst,
    input display_pkg::rgb_t rgb,
    input logic              hsync,
    input logic              vsync,
    input logic              blank,
    input logic              frame_end
);
    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////
    // output and timing rules
    //////////////////////////////////////////////////

    // no colour may leak into the border
    blank_gates_rgb: assert property (@(posedge vclock) disable iff (rst)
        blank |-> (rgb == `BLANK_COLOR))
        else $error("rgb is not black while blank is high");

    frame_end_single: assert property (@(posedge vclock) disable iff (rst)
        frame_end |=> !frame_end)                    // one pulse per frame
        else $error("frame_end stayed high for more than one cycle");

    // vsync moves at line start, hsync rises late in the line
    hsync_rise_vsync_stable: assert property (@(posedge vclock) disable iff (rst)
        $rose(hsync) |-> $stable(vsync))
        else $error("hsync rose while vsync was changing");

endmodule

//--- bench/display_tb.sv
`include "display_consts.svh"

module display_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import display_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_FRAMES   = 40;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;     // 4320 pixels incl. blanking
    localparam int HALF         = `SPRITE_SIZE / 2;
    localparam logic [26:0] IDLE_OUT = {24'(`BLANK_COLOR), 1'b0, 1'b0, 1'b1};

    logic     vclock = 1'b0;
    logic     rst;
    logic     load;
    coord_t   new_x;
    coord_t   new_y;
    heading_t new_heading;
    rgb_t     rgb;
    logic     hsync;
    logic     vsync;
    logic     blank;

    integer      seed = 32'h84d6;
    int          h;                 // model raster position that follows the DUT counters
    int          v;
    int          act_x;             // model of the active registers
    int          act_y;
    int          act_hd;
    int          pend_x;            // model of the pending registers
    int          pend_y;
    int          pend_hd;
    int          load_row;          // where this frame's load lands
    int          load_col;
    logic [26:0] exp_d1;            // {rgb, hsync, vsync, blank} predicted one cycle ago
    logic [26:0] exp_d2;            // two cycles old and due at the outputs now

    always #(CLK_PERIOD / 2) vclock = ~vclock;

    phone_display phone_display_i (
        .vclock      (vclock),
        .rst         (rst),
        .load        (load),
        .new_x       (new_x),
        .new_y       (new_y),
        .new_heading (new_heading),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync),
        .blank       (blank)
    );

    bind phone_display display_assertions display_assertions_i (
        .vclock    (vclock),
        .rst       (rst),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync),
        .blank     (blank),
        .frame_end (frame_end)     // internal pulse of the top level
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic int rand_range(int lo, int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    // sprite colour straight from the box, ray and quadrant rules
    function automatic logic [23:0] sprite_model(int px, int py, int cx, int cy, int hd);
        int   dx;
        int   dy;
        int   ax;
        int   ay;
        int   t75;
        logic ray;
        logic quad_ok;
        dx = px - cx;
        dy = py - cy;
        ax = (dx < 0) ? -dx : dx;
        ay = (dy < 0) ? -dy : dy;
        if (dx < -HALF || dx >= HALF || dy < -HALF || dy >= HALF) begin
            return 24'(`BLANK_COLOR);                   // outside the square
        end
        t75 = ax * `TAN75_NUM / 64 - ay;
        ray = (ay == 0 && ax != 0) || (ax == 0 && ay != 0) || (ax == ay)
           || (ax * `TAN15_NUM / 64 == ay) || (ax * `TAN30_NUM / 64 == ay)
           || (ax * `TAN60_NUM / 64 == ay)
           || (t75 >= -`TAN75_SLACK && t75 <= 0);    // widened steep ray
        case (hd / 6)                                   // y grows downward
            0:       quad_ok = (dx >= 0) && (dy <= 0);
            1:       quad_ok = (dx <= 0) && (dy <= 0);
            2:       quad_ok = (dx <= 0) && (dy >= 0);
            default: quad_ok = (dx >= 0) && (dy >= 0);
        endcase
        return (ray && quad_ok) ? 24'(`INDICATOR_COLOR) : 24'(`BODY_COLOR);
    endfunction

    // full output word for one raster position
    function automatic logic [26:0] predict(int px, int py);
        logic        hs;
        logic        vs;
        logic        bl;
        logic [23:0] color;
        hs = px >= `H_ACTIVE + `H_FRONT && px < `H_ACTIVE + `H_FRONT + `H_SYNC;
        vs = py >= `V_ACTIVE + `V_FRONT && py < `V_ACTIVE + `V_FRONT + `V_SYNC;
        bl = px >= `H_ACTIVE || py >= `V_ACTIVE;
        color = bl ? 24'(`BLANK_COLOR) : sprite_model(px, py, act_x, act_y, act_hd);
        return {color, hs, vs, bl};
    endfunction

    //////////////////////////////////////////////////
    // checks and stimulus
    //////////////////////////////////////////////////

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs(logic [26:0] e);
        check_value("rgb", 32'(rgb), 32'(e[26:3]));
        check_value("hsync", 32'(hsync), 32'(e[2]));
        check_value("vsync", 32'(vsync), 32'(e[1]));
        check_value("blank", 32'(blank), 32'(e[0]));
    endtask

    // check, drive, then advance the model over the coming edge
    task automatic step_cycle();
        compare_outputs(exp_d2);
        exp_d2 = exp_d1;
        exp_d1 = predict(h, v);
        if (h == 0 && v == 0) begin
            load_row = rand_range(5, 40);               // mid-frame load
            load_col = rand_range(0, `H_TOTAL - 1);
        end
        load        = (v == load_row) && (h == load_col);
        new_x       = coord_t'(rand_range(-16, 80));    // junk unless load is high
        new_y       = coord_t'(rand_range(-16, 80));
        new_heading = heading_t'(rand_range(0, 23));
        if (h == `H_TOTAL - 1 && v == `V_TOTAL - 1) begin
            act_x  = pend_x;                            // swap sees the old pending
            act_y  = pend_y;
            act_hd = pend_hd;
        end
        if (load) begin
            pend_x  = int'(new_x);
            pend_y  = int'(new_y);
            pend_hd = int'(new_heading);
        end
        h = (h == `H_TOTAL - 1) ? 0 : h + 1;
        if (h == 0) begin
            v = (v == `V_TOTAL - 1) ? 0 : v + 1;
        end
    endtask

    initial begin
        rst         = 1'b1;
        load        = 1'b0;
        new_x       = '0;
        new_y       = '0;
        new_heading = '0;
        h           = 0;
        v           = 0;
        act_x       = 0;
        act_y       = 0;
        act_hd      = 0;
        pend_x      = 0;
        pend_y      = 0;
        pend_hd     = 0;
        load_row    = 0;
        load_col    = 0;
        exp_d1      = IDLE_OUT;                         // pipe still filling
        exp_d2      = IDLE_OUT;
        repeat (RESET_CYCLES) @(posedge vclock);
        #1;
        rst = 1'b0;
        for (int c = 0; c < NUM_FRAMES * FRAME_CYCLES + 2; c++) begin
            step_cycle();
            @(posedge vclock);
            #1;
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // watchdog with a few spare frames beyond the full run
    initial begin
        #((RESET_CYCLES + (NUM_FRAMES + 5) * FRAME_CYCLES) * CLK_PERIOD);
        $display("timeout: the run did not finish %0d frames in time", NUM_FRAMES);
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/display_pkg.sv
verilog/delay_line.sv
verilog/raster_timing.sv
verilog/position_register.sv
verilog/heading_sprite.sv
verilog/video_out.sv
verilog/phone_display.sv
bench/display_assertions.sv
bench/display_tb.sv

//--- Makefile
# Verilator build and run for the heading display

VERILATOR ?= verilator
TOP       ?= display_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
SRCS      := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, not the exit code of the simulator
run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
